//--- filelist.f
+incdir+include
logic/mips_id_pkg.sv
logic/reg_file.sv
logic/inst_decoder.sv
logic/operand_bypass.sv
logic/branch_resolver.sv
logic/id_ex_latch.sv
logic/id_stage.sv
verification/id_stage_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the decode stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
  --top-module id_stage_tb \
  -f filelist.f \
  -o id_stage_sim \
  || { echo "build failed"; exit 1; }

./obj_dir/id_stage_sim | tee /dev/stderr | grep -q "TESTS PASSED" \
  && exit 0 \
  || exit 1

//--- include/id_tb_vectors.svh
localparam fwd_t NOF = '0;

// one row per call, fields in the order inst, pc, in_delay_slot, ex_fwd, mem_fwd,
//   aluop, alusel, wd, wreg, op1 src and value, op2 src and value, branch,
//   target src and value, link, stall
task automatic load_vectors();
  add_row(enc_r(1, 2, 3, 0, FN_OR), 'h100, 0, NOF, NOF,
          ALU_OR, SEL_LOGIC, 3, 1, SRC_REG, 1, SRC_REG, 2, 0, TGT_NONE, 0, 0, 0);
  add_row(enc_r(5, 2, 4, 0, FN_SRAV), 'h104, 0, NOF, NOF,
          ALU_SRAV, SEL_SHIFT, 4, 1, SRC_REG, 5, SRC_REG, 2, 0, TGT_NONE, 0, 0, 0);
  add_row(enc_r(6, 8, 7, 0, FN_SUBU), 'h108, 0, NOF, NOF,
          ALU_SUBU, SEL_ARITHMETIC, 7, 1, SRC_REG, 6, SRC_REG, 8, 0, TGT_NONE, 0, 0, 0);
  add_row(enc_i(OP_ORI, 1, 9, 'h8001), 'h10c, 0, NOF, NOF,
          ALU_OR, SEL_LOGIC, 9, 1, SRC_REG, 1, SRC_IMM, 'h8001, 0, TGT_NONE, 0, 0, 0);
  add_row(enc_i(OP_ADDI, 2, 10, 'hfff0), 'h110, 0, NOF, NOF,
          ALU_ADDI, SEL_ARITHMETIC, 10, 1, SRC_REG, 2, SRC_IMM, 'hfffffff0, 0, TGT_NONE, 0, 0, 0);
  add_row(enc_i(OP_SLTI, 3, 11, 'h8000), 'h114, 0, NOF, NOF,
          ALU_SLT, SEL_ARITHMETIC, 11, 1, SRC_REG, 3, SRC_IMM, 'hffff8000, 0, TGT_NONE, 0, 0, 0);
  add_row(enc_i(OP_LUI, 0, 12, 'h1234), 'h118, 0, NOF, NOF,
          ALU_OR, SEL_LOGIC, 12, 1, SRC_REG, 0, SRC_IMM, 'h12340000, 0, TGT_NONE, 0, 0, 0);
  add_row(enc_r(0, 4, 13, 7, FN_SLL), 'h11c, 0, NOF, NOF,
          ALU_SLL, SEL_SHIFT, 13, 1, SRC_IMM, 7, SRC_REG, 4, 0, TGT_NONE, 0, 0, 0);
  add_row(enc_r(0, 5, 14, 31, FN_SRA), 'h120, 0, NOF, NOF,
          ALU_SRA, SEL_SHIFT, 14, 1, SRC_IMM, 31, SRC_REG, 5, 0, TGT_NONE, 0, 0, 0);
  add_row(enc_r(0, 6, 16, 16, FN_SRL), 'h140, 0, NOF, NOF,
          ALU_SRL, SEL_SHIFT, 16, 1, SRC_IMM, 16, SRC_REG, 6, 0, TGT_NONE, 0, 0, 0);
  add_row(enc_i(OP_LW, 3, 20, 8), 'h124, 0, NOF, NOF,
          ALU_LW, SEL_LOAD_STORE, 20, 1, SRC_REG, 3, SRC_IMM, 8, 0, TGT_NONE, 0, 0, 0);
  // forwarding, execute over memory
  add_row(enc_r(1, 2, 15, 0, FN_ADD), 'h128, 0, make_fwd(1, 1, 'haaaa0001, ALU_ADD),
          make_fwd(1, 1, 'hbbbb0001, ALU_ADDU),
          ALU_ADD, SEL_ARITHMETIC, 15, 1, SRC_FWD, 'haaaa0001, SRC_REG, 2, 0, TGT_NONE, 0, 0, 0);
  add_row(enc_r(1, 2, 15, 0, FN_ADD), 'h12c, 0, NOF, make_fwd(1, 1, 'hcccc0002, ALU_OR),
          ALU_ADD, SEL_ARITHMETIC, 15, 1, SRC_FWD, 'hcccc0002, SRC_REG, 2, 0, TGT_NONE, 0, 0, 0);
  // load-use, then a non-load on the same register
  add_row(enc_r(1, 2, 3, 0, FN_AND), 'h130, 0, make_fwd(1, 1, 0, ALU_LW), NOF,
          ALU_AND, SEL_LOGIC, 3, 1, SRC_REG, 1, SRC_REG, 2, 0, TGT_NONE, 0, 0, 1);
  add_row(enc_r(1, 2, 3, 0, FN_AND), 'h134, 0, make_fwd(1, 1, 'hdddd0003, ALU_ADD), NOF,
          ALU_AND, SEL_LOGIC, 3, 1, SRC_FWD, 'hdddd0003, SRC_REG, 2, 0, TGT_NONE, 0, 0, 0);
  // jumps and branches
  add_row(enc_j(OP_J, 'h0120456), 'ha0000100, 0, NOF, NOF,
          ALU_J, SEL_JUMP_BRANCH, 0, 0, SRC_IMM, 0, SRC_IMM, 0, 1, TGT_VAL, 'ha0481158, 0, 0);
  add_row(enc_j(OP_JAL, 'h0000400), 'h00400000, 0, NOF, NOF,
          ALU_JAL, SEL_JUMP_BRANCH, 31, 1, SRC_IMM, 0, SRC_IMM, 0, 1, TGT_VAL, 'h1000,
          'h00400008, 0);
  add_row(enc_r(6, 0, 0, 0, FN_JR), 'h3000, 0, NOF, NOF,
          ALU_JR, SEL_JUMP_BRANCH, 0, 0, SRC_REG, 6, SRC_IMM, 0, 1, TGT_REG1, 0, 0, 0);
  add_row(enc_i(OP_BEQ, 7, 7, 'hfffe), 'h1000, 1, NOF, NOF,
          ALU_BEQ, SEL_JUMP_BRANCH, 31, 0, SRC_REG, 7, SRC_REG, 7, 1, TGT_VAL, 'hffc, 0, 0);
  add_row(enc_i(OP_BEQ, 1, 2, 'h0010), 'h2000, 1, NOF, NOF,
          ALU_BEQ, SEL_JUMP_BRANCH, 0, 0, SRC_REG, 1, SRC_REG, 2, 0, TGT_NONE, 0, 0, 0);
endtask

//--- verification/id_stage_tb.sv
`timescale 1ns/1ps

module id_stage_tb;
  import mips_id_pkg::*;

  localparam int EDGE_LIMIT = 20;

  // where an expected operand comes from
  typedef enum logic [1:0] {SRC_REG, SRC_FWD, SRC_IMM} src_e;
  typedef enum logic [1:0] {TGT_NONE, TGT_VAL, TGT_REG1} tgt_e;

  typedef struct packed {
    word_t     inst;
    word_t     pc;
    logic      ds;
    fwd_t      ex_fwd;
    fwd_t      mem_fwd;
    aluop_e    aluop;
    alusel_e   alusel;
    reg_addr_t wd;
    logic      wreg;
    src_e      s1;
    word_t     v1;
    src_e      s2;
    word_t     v2;
    logic      br;
    tgt_e      tgt_sel;
    word_t     tgt;
    word_t     link;
    logic      stall;
  } vec_t;

  logic        clk = 1'b0;
  logic        rst;
  word_t       pc;
  word_t       inst;
  logic        ds;
  fwd_t        ex_fwd;
  fwd_t        mem_fwd;
  fwd_t        wb;
  id_ex_t      id_ex;
  logic        branch_flag;
  word_t       branch_addr;
  logic        next_ds;
  logic        stall;
  int unsigned edges = 0;
  int          checks = 0;
  int          errors = 0;
  logic        timed_out = 1'b0;
  word_t       model [32];
  logic [31:0] lfsr_state;
  vec_t        vecs [$];
  word_t       w;

  id_stage #(
    .RESET_PC (32'h0)
  ) dut0 (
    .clk_i                (clk),
    .rst_i                (rst),
    .pc_i                 (pc),
    .inst_i               (inst),
    .in_delay_slot_i      (ds),
    .ex_fwd_i             (ex_fwd),
    .mem_fwd_i            (mem_fwd),
    .wb_i                 (wb),
    .id_ex_o              (id_ex),
    .branch_flag_o        (branch_flag),
    .branch_addr_o        (branch_addr),
    .next_in_delay_slot_o (next_ds),
    .stall_o              (stall)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    edges <= edges + 1;
  end

  function automatic word_t enc_r(int rs, int rt, int rd, int sh, logic [5:0] fn);
    return {OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
  endfunction

  function automatic word_t enc_i(logic [5:0] op, int rs, int rt, int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
  endfunction

  function automatic word_t enc_j(logic [5:0] op, int idx);
    return {op, 26'(idx)};
  endfunction

  function automatic fwd_t make_fwd(int wreg, int wd, int data, aluop_e op);
    fwd_t f;
    f.wreg  = (wreg != 0);
    f.wd    = 5'(wd);
    f.wdata = data;
    f.aluop = op;
    return f;
  endfunction

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_word(output word_t word);
    word = '0;
    for (int b = 0; b < 32; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      word       = {word[30:0], lfsr_state[0]};
    end
  endtask

  task automatic add_row(word_t i, int p, int d, fwd_t exf, fwd_t memf, aluop_e op,
                         alusel_e sel, int wd, int wreg, src_e s1, int v1, src_e s2,
                         int v2, int br, tgt_e ts, int tgt, int link, int st);
    vec_t v;
    v.inst    = i;
    v.pc      = p;
    v.ds      = (d != 0);
    v.ex_fwd  = exf;
    v.mem_fwd = memf;
    v.aluop   = op;
    v.alusel  = sel;
    v.wd      = 5'(wd);
    v.wreg    = (wreg != 0);
    v.s1      = s1;
    v.v1      = v1;
    v.s2      = s2;
    v.v2      = v2;
    v.br      = (br != 0);
    v.tgt_sel = ts;
    v.tgt     = tgt;
    v.link    = link;
    v.stall   = (st != 0);
    vecs.push_back(v);
  endtask

  `include "id_tb_vectors.svh"

  task automatic check_bit(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_id_ex(string name, id_ex_t got, id_ex_t exp);
    check_word({name, ".aluop"}, 32'(got.aluop), 32'(exp.aluop));
    check_word({name, ".alusel"}, 32'(got.alusel), 32'(exp.alusel));
    check_word({name, ".reg1"}, got.reg1, exp.reg1);
    check_word({name, ".reg2"}, got.reg2, exp.reg2);
    check_word({name, ".wd"}, 32'(got.wd), 32'(exp.wd));
    check_bit({name, ".wreg"}, got.wreg, exp.wreg);
    check_word({name, ".link_addr"}, got.link_addr, exp.link_addr);
    check_word({name, ".inst"}, got.inst, exp.inst);
    check_bit({name, ".in_delay_slot"}, got.in_delay_slot, exp.in_delay_slot);
  endtask

  // returns half a nanosecond after the next rising edge
  task automatic next_edge();
    int unsigned start;
    int          t;
    start = edges;
    t     = 0;
    while (!timed_out && edges == start && t < EDGE_LIMIT) begin
      #1;
      t++;
    end
    if (!timed_out && edges == start) begin
      timed_out = 1'b1;
      errors++;
      $display("timeout: no clock edge within %0d ns", EDGE_LIMIT);
    end
  endtask

  function automatic word_t operand_value(src_e s, word_t v);
    if (s == SRC_REG) begin
      return model[v[4:0]];
    end
    return v;
  endfunction

  task automatic apply_row(vec_t v, int idx);
    word_t  op1;
    word_t  op2;
    id_ex_t exp;
    string  tag;
    op1     = operand_value(v.s1, v.v1);
    op2     = operand_value(v.s2, v.v2);
    tag     = $sformatf("row %0d ", idx);
    inst    = v.inst;
    pc      = v.pc;
    ds      = v.ds;
    ex_fwd  = v.ex_fwd;
    mem_fwd = v.mem_fwd;
    #4.5;
    check_bit({tag, "stall_o"}, stall, v.stall);
    check_bit({tag, "branch_flag_o"}, branch_flag, v.br);
    check_bit({tag, "next_in_delay_slot_o"}, next_ds, v.br);
    if (v.br) begin
      check_word({tag, "branch_addr_o"}, branch_addr, (v.tgt_sel == TGT_REG1) ? op1 : v.tgt);
    end
    // a stalled row leaves a bubble behind
    exp = '0;
    if (!v.stall) begin
      exp.aluop         = v.aluop;
      exp.alusel        = v.alusel;
      exp.reg1          = op1;
      exp.reg2          = op2;
      exp.wd            = v.wd;
      exp.wreg          = v.wreg;
      exp.link_addr     = v.link;
      exp.inst          = v.inst;
      exp.in_delay_slot = v.ds;
    end
    next_edge();
    #0.5;
    check_id_ex({tag, "id_ex_o"}, id_ex, exp);
  endtask

  initial begin
    rst     = 1'b1;
    pc      = '0;
    inst    = '0;
    ds      = 1'b0;
    ex_fwd  = '0;
    mem_fwd = '0;
    wb      = '0;
    for (int i = 0; i < 32; i++) begin
      model[i] = '0;
    end
    lfsr_state = 32'h5944;
    load_vectors();
    #0.5;
    repeat (16) next_edge();
    #0.5;
    rst = 1'b0;
    #4.5;
    check_id_ex("reset id_ex_o", id_ex, '0);
    check_bit("reset branch_flag_o", branch_flag, 1'b0);
    check_bit("reset stall_o", stall, 1'b0);
    next_edge();
    #0.5;
    // preload r1..r8 through write-back
    for (int r = 1; r <= 8; r++) begin
      take_word(w);
      wb       = make_fwd(1, r, w, ALU_ADD);
      model[r] = w;
      next_edge();
      #0.5;
    end
    wb = '0;
    foreach (vecs[i]) begin
      apply_row(vecs[i], i);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- logic/id_stage.sv
`timescale 1ns/1ps

module id_stage #(
  parameter mips_id_pkg::word_t RESET_PC = '0
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  mips_id_pkg::word_t  pc_i,
  input  mips_id_pkg::word_t  inst_i,
  input  logic                in_delay_slot_i,
  input  mips_id_pkg::fwd_t   ex_fwd_i,
  input  mips_id_pkg::fwd_t   mem_fwd_i,
  input  mips_id_pkg::fwd_t   wb_i,
  output mips_id_pkg::id_ex_t id_ex_o,
  output logic                branch_flag_o,
  output mips_id_pkg::word_t  branch_addr_o,
  output logic                next_in_delay_slot_o,
  output logic                stall_o
);
  import mips_id_pkg::*;

  decode_t dec;
  word_t   rf_data1;
  word_t   rf_data2;
  word_t   reg1;
  word_t   reg2;
  word_t   link_addr;
  logic    stall1;
  logic    stall2;

  reg_file rf (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .wb_i     (wb_i),
    .raddr1_i (dec.reg1_addr),
    .raddr2_i (dec.reg2_addr),
    .rdata1_o (rf_data1),
    .rdata2_o (rf_data2)
  );

  inst_decoder decoder (
    .rst_i  (rst_i),
    .inst_i (inst_i),
    .dec_o  (dec)
  );

  operand_bypass op1 (
    .read_i    (dec.reg1_read),
    .addr_i    (dec.reg1_addr),
    .imm_i     (dec.imm),
    .rf_data_i (rf_data1),
    .ex_fwd_i  (ex_fwd_i),
    .mem_fwd_i (mem_fwd_i),
    .operand_o (reg1),
    .stall_o   (stall1)
  );

  operand_bypass op2 (
    .read_i    (dec.reg2_read),
    .addr_i    (dec.reg2_addr),
    .imm_i     (dec.imm),
    .rf_data_i (rf_data2),
    .ex_fwd_i  (ex_fwd_i),
    .mem_fwd_i (mem_fwd_i),
    .operand_o (reg2),
    .stall_o   (stall2)
  );

  // either operand waiting on a load holds the stage
  assign stall_o = stall1 | stall2;

  branch_resolver br (
    .dec_i                (dec),
    .pc_i                 (pc_i),
    .inst_i               (inst_i),
    .reg1_i               (reg1),
    .reg2_i               (reg2),
    .branch_flag_o        (branch_flag_o),
    .branch_addr_o        (branch_addr_o),
    .link_addr_o          (link_addr),
    .next_in_delay_slot_o (next_in_delay_slot_o)
  );

  id_ex_latch #(
    .RESET_PC (RESET_PC)
  ) latch (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .stall_i         (stall_o),
    .dec_i           (dec),
    .reg1_i          (reg1),
    .reg2_i          (reg2),
    .link_addr_i     (link_addr),
    .inst_i          (inst_i),
    .in_delay_slot_i (in_delay_slot_i),
    .id_ex_o         (id_ex_o)
  );

endmodule

//--- logic/id_ex_latch.sv
`timescale 1ns/1ps

module id_ex_latch #(
  parameter mips_id_pkg::word_t RESET_PC = '0
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 stall_i,
  input  mips_id_pkg::decode_t dec_i,
  input  mips_id_pkg::word_t   reg1_i,
  input  mips_id_pkg::word_t   reg2_i,
  input  mips_id_pkg::word_t   link_addr_i,
  input  mips_id_pkg::word_t   inst_i,
  input  logic                 in_delay_slot_i,
  output mips_id_pkg::id_ex_t  id_ex_o
);
  import mips_id_pkg::*;

  localparam id_ex_t BUBBLE = '{aluop: ALU_NOP, alusel: SEL_NOP, link_addr: RESET_PC,
                                default: '0};

  always_ff @(posedge clk_i) begin
    if (rst_i || stall_i) begin
      id_ex_o <= BUBBLE;
    end else begin
      id_ex_o.aluop         <= dec_i.aluop;
      id_ex_o.alusel        <= dec_i.alusel;
      id_ex_o.reg1          <= reg1_i;
      id_ex_o.reg2          <= reg2_i;
      id_ex_o.wd            <= dec_i.wd;
      id_ex_o.wreg          <= dec_i.wreg;
      id_ex_o.link_addr     <= link_addr_i;
      id_ex_o.inst          <= inst_i;
      id_ex_o.in_delay_slot <= in_delay_slot_i;
    end
  end

endmodule

//--- logic/branch_resolver.sv
`timescale 1ns/1ps

module branch_resolver (
  input  mips_id_pkg::decode_t dec_i,
  input  mips_id_pkg::word_t   pc_i,
  input  mips_id_pkg::word_t   inst_i,
  input  mips_id_pkg::word_t   reg1_i,
  input  mips_id_pkg::word_t   reg2_i,
  output logic                 branch_flag_o,
  output mips_id_pkg::word_t   branch_addr_o,
  output mips_id_pkg::word_t   link_addr_o,
  output logic                 next_in_delay_slot_o
);
  import mips_id_pkg::*;

  word_t pc_plus_4;
  word_t pc_plus_8;
  word_t jump_target;
  word_t beq_target;

  assign pc_plus_4 = pc_i + 32'd4;
  assign pc_plus_8 = pc_i + 32'd8;

  // region of the delay slot, then the 26-bit word index
  assign jump_target = {pc_plus_4[31:28], inst_i[25:0], 2'b00};
  assign beq_target  = pc_plus_4 + {dec_i.imm[29:0], 2'b00};

  always_comb begin
    branch_flag_o = 1'b0;
    branch_addr_o = '0;
    case (dec_i.branch_kind)
      BR_JUMP_IMM: begin
        branch_flag_o = 1'b1;
        branch_addr_o = jump_target;
      end
      BR_JUMP_REG: begin
        branch_flag_o = 1'b1;
        branch_addr_o = reg1_i;
      end
      BR_BEQ: begin
        if (reg1_i == reg2_i) begin
          branch_flag_o = 1'b1;
          branch_addr_o = beq_target;
        end
      end
      default: ;
    endcase
  end

  // return past the delay slot
  assign link_addr_o          = dec_i.link ? pc_plus_8 : '0;
  assign next_in_delay_slot_o = branch_flag_o;

endmodule

//--- logic/operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass (
  input  logic                   read_i,
  input  mips_id_pkg::reg_addr_t addr_i,
  input  mips_id_pkg::word_t     imm_i,
  input  mips_id_pkg::word_t     rf_data_i,
  input  mips_id_pkg::fwd_t      ex_fwd_i,
  input  mips_id_pkg::fwd_t      mem_fwd_i,
  output mips_id_pkg::word_t     operand_o,
  output logic                   stall_o
);
  import mips_id_pkg::*;

  logic ex_hit;
  logic mem_hit;
  logic load_use;

  assign ex_hit  = read_i && ex_fwd_i.wreg && (ex_fwd_i.wd == addr_i);
  assign mem_hit = read_i && mem_fwd_i.wreg && (mem_fwd_i.wd == addr_i);

  // load data only exists after the memory stage
  assign load_use = read_i && (ex_fwd_i.aluop == ALU_LW) && (ex_fwd_i.wd == addr_i);
  assign stall_o  = load_use;

  // execute wins over memory, memory over the register file
  always_comb begin
    if (load_use) begin
      operand_o = '0;
    end else if (ex_hit) begin
      operand_o = ex_fwd_i.wdata;
    end else if (mem_hit) begin
      operand_o = mem_fwd_i.wdata;
    end else if (read_i) begin
      operand_o = rf_data_i;
    end else begin
      operand_o = imm_i;
    end
    // an lw in execute always carries its write enable
    assert (!stall_o || ex_fwd_i.wreg)
      else $error("load-use stall on an lw without its write enable");
  end

endmodule

//--- logic/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
  input  logic                 rst_i,
  input  mips_id_pkg::word_t   inst_i,
  output mips_id_pkg::decode_t dec_o
);
  import mips_id_pkg::*;

  logic [5:0]  op;
  reg_addr_t   rs;
  reg_addr_t   rt;
  reg_addr_t   rd;
  logic [4:0]  shamt;
  logic [5:0]  funct;
  logic [15:0] imm;
  word_t       imm_val;
  logic        writes_rt;

  assign op    = inst_i[31:26];
  assign rs    = inst_i[25:21];
  assign rt    = inst_i[20:16];
  assign rd    = inst_i[15:11];
  assign shamt = inst_i[10:6];
  assign funct = inst_i[5:0];
  assign imm   = inst_i[15:0];

  // i-type results go to rt
  assign writes_rt = op inside {OP_ORI, OP_ANDI, OP_XORI, OP_LUI, OP_ADDI, OP_ADDIU,
                                OP_SLTI, OP_SLTIU, OP_LW};

  always_comb begin
    case (op)
      OP_SPECIAL:              imm_val = {27'd0, shamt};
      OP_ORI, OP_ANDI, OP_XORI: imm_val = {16'd0, imm};
      OP_LUI:                  imm_val = {imm, 16'd0};
      OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_LW, OP_SW, OP_BEQ: begin
        imm_val = {{16{imm[15]}}, imm};
      end
      default:                 imm_val = '0;
    endcase
  end

  function automatic decode_t set_op(decode_t d, aluop_e aluop, alusel_e alusel,
                                     logic wreg, logic rd1, logic rd2);
    decode_t r;
    r           = d;
    r.aluop     = aluop;
    r.alusel    = alusel;
    r.wreg      = wreg;
    r.reg1_read = rd1;
    r.reg2_read = rd2;
    return r;
  endfunction

  always_comb begin
    dec_o = '0;
    if (!rst_i) begin
      dec_o.wd        = writes_rt ? rt : rd;
      dec_o.reg1_addr = rs;
      dec_o.reg2_addr = rt;
      dec_o.imm       = imm_val;
      case (op)
        OP_SPECIAL: begin
          if (shamt == 5'd0) begin
            case (funct)
              FN_OR:   dec_o = set_op(dec_o, ALU_OR, SEL_LOGIC, 1'b1, 1'b1, 1'b1);
              FN_AND:  dec_o = set_op(dec_o, ALU_AND, SEL_LOGIC, 1'b1, 1'b1, 1'b1);
              FN_XOR:  dec_o = set_op(dec_o, ALU_XOR, SEL_LOGIC, 1'b1, 1'b1, 1'b1);
              FN_NOR:  dec_o = set_op(dec_o, ALU_NOR, SEL_LOGIC, 1'b1, 1'b1, 1'b1);
              FN_SLLV: dec_o = set_op(dec_o, ALU_SLLV, SEL_SHIFT, 1'b1, 1'b1, 1'b1);
              FN_SRLV: dec_o = set_op(dec_o, ALU_SRLV, SEL_SHIFT, 1'b1, 1'b1, 1'b1);
              FN_SRAV: dec_o = set_op(dec_o, ALU_SRAV, SEL_SHIFT, 1'b1, 1'b1, 1'b1);
              FN_SLT:  dec_o = set_op(dec_o, ALU_SLT, SEL_ARITHMETIC, 1'b1, 1'b1, 1'b1);
              FN_SLTU: dec_o = set_op(dec_o, ALU_SLTU, SEL_ARITHMETIC, 1'b1, 1'b1, 1'b1);
              FN_ADD:  dec_o = set_op(dec_o, ALU_ADD, SEL_ARITHMETIC, 1'b1, 1'b1, 1'b1);
              FN_ADDU: dec_o = set_op(dec_o, ALU_ADDU, SEL_ARITHMETIC, 1'b1, 1'b1, 1'b1);
              FN_SUB:  dec_o = set_op(dec_o, ALU_SUB, SEL_ARITHMETIC, 1'b1, 1'b1, 1'b1);
              FN_SUBU: dec_o = set_op(dec_o, ALU_SUBU, SEL_ARITHMETIC, 1'b1, 1'b1, 1'b1);
              FN_JR: begin
                dec_o = set_op(dec_o, ALU_JR, SEL_JUMP_BRANCH, 1'b0, 1'b1, 1'b0);
                dec_o.branch_kind = BR_JUMP_REG;
              end
              FN_JALR: begin
                dec_o = set_op(dec_o, ALU_JALR, SEL_JUMP_BRANCH, 1'b1, 1'b1, 1'b0);
                dec_o.branch_kind = BR_JUMP_REG;
                dec_o.link        = 1'b1;
              end
              default: ;
            endcase
          end
        end
        OP_ORI:   dec_o = set_op(dec_o, ALU_OR, SEL_LOGIC, 1'b1, 1'b1, 1'b0);
        OP_ANDI:  dec_o = set_op(dec_o, ALU_AND, SEL_LOGIC, 1'b1, 1'b1, 1'b0);
        OP_XORI:  dec_o = set_op(dec_o, ALU_XOR, SEL_LOGIC, 1'b1, 1'b1, 1'b0);
        OP_LUI:   dec_o = set_op(dec_o, ALU_OR, SEL_LOGIC, 1'b1, 1'b1, 1'b0);
        OP_SLTI:  dec_o = set_op(dec_o, ALU_SLT, SEL_ARITHMETIC, 1'b1, 1'b1, 1'b0);
        OP_SLTIU: dec_o = set_op(dec_o, ALU_SLTU, SEL_ARITHMETIC, 1'b1, 1'b1, 1'b0);
        OP_ADDI:  dec_o = set_op(dec_o, ALU_ADDI, SEL_ARITHMETIC, 1'b1, 1'b1, 1'b0);
        OP_ADDIU: dec_o = set_op(dec_o, ALU_ADDIU, SEL_ARITHMETIC, 1'b1, 1'b1, 1'b0);
        OP_LW:    dec_o = set_op(dec_o, ALU_LW, SEL_LOAD_STORE, 1'b1, 1'b1, 1'b0);
        OP_SW:    dec_o = set_op(dec_o, ALU_SW, SEL_LOAD_STORE, 1'b0, 1'b1, 1'b1);
        OP_J: begin
          dec_o = set_op(dec_o, ALU_J, SEL_JUMP_BRANCH, 1'b0, 1'b0, 1'b0);
          dec_o.branch_kind = BR_JUMP_IMM;
        end
        OP_JAL: begin
          dec_o = set_op(dec_o, ALU_JAL, SEL_JUMP_BRANCH, 1'b1, 1'b0, 1'b0);
          dec_o.wd          = LINK_REG;
          dec_o.branch_kind = BR_JUMP_IMM;
          dec_o.link        = 1'b1;
        end
        OP_BEQ: begin
          dec_o = set_op(dec_o, ALU_BEQ, SEL_JUMP_BRANCH, 1'b0, 1'b1, 1'b1);
          dec_o.branch_kind = BR_BEQ;
        end
        default: ;
      endcase
      // shift by shamt, rs field must be zero
      if (inst_i[31:21] == 11'd0) begin
        case (funct)
          FN_SLL:  dec_o = set_op(dec_o, ALU_SLL, SEL_SHIFT, 1'b1, 1'b0, 1'b1);
          FN_SRL:  dec_o = set_op(dec_o, ALU_SRL, SEL_SHIFT, 1'b1, 1'b0, 1'b1);
          FN_SRA:  dec_o = set_op(dec_o, ALU_SRA, SEL_SHIFT, 1'b1, 1'b0, 1'b1);
          default: ;
        endcase
      end
    end
  end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  mips_id_pkg::fwd_t      wb_i,
  input  mips_id_pkg::reg_addr_t raddr1_i,
  input  mips_id_pkg::reg_addr_t raddr2_i,
  output mips_id_pkg::word_t     rdata1_o,
  output mips_id_pkg::word_t     rdata2_o
);
  import mips_id_pkg::*;

  localparam int NUM_REGS = 2 ** REG_ADDR_W;

  word_t regs [NUM_REGS];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_i.wreg && (wb_i.wd != '0)) begin
      regs[wb_i.wd] <= wb_i.wdata;
    end
  end

  // write-through so decode sees a result retiring this cycle
  function automatic word_t read_port(reg_addr_t addr, fwd_t wb, word_t stored);
    word_t data;
    if (addr == '0) begin
      data = '0;
    end else if (wb.wreg && (wb.wd == addr)) begin
      data = wb.wdata;
    end else begin
      data = stored;
    end
    return data;
  endfunction

  assign rdata1_o = read_port(raddr1_i, wb_i, regs[raddr1_i]);
  assign rdata2_o = read_port(raddr2_i, wb_i, regs[raddr2_i]);

endmodule

//--- logic/mips_id_pkg.sv
package mips_id_pkg;

  localparam int REG_W      = 32;
  localparam int REG_ADDR_W = 5;

  typedef logic [REG_W-1:0]      word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // jal writes its return address here
  localparam reg_addr_t LINK_REG = 5'd31;

  // primary opcodes
  localparam logic [5:0] OP_SPECIAL = 6'b000000;
  localparam logic [5:0] OP_J       = 6'b000010;
  localparam logic [5:0] OP_JAL     = 6'b000011;
  localparam logic [5:0] OP_BEQ     = 6'b000100;
  localparam logic [5:0] OP_ADDI    = 6'b001000;
  localparam logic [5:0] OP_ADDIU   = 6'b001001;
  localparam logic [5:0] OP_SLTI    = 6'b001010;
  localparam logic [5:0] OP_SLTIU   = 6'b001011;
  localparam logic [5:0] OP_ANDI    = 6'b001100;
  localparam logic [5:0] OP_ORI     = 6'b001101;
  localparam logic [5:0] OP_XORI    = 6'b001110;
  localparam logic [5:0] OP_LUI     = 6'b001111;
  localparam logic [5:0] OP_LW      = 6'b100011;
  localparam logic [5:0] OP_SW      = 6'b101011;

  // funct field of the special opcode
  localparam logic [5:0] FN_SLL  = 6'b000000;
  localparam logic [5:0] FN_SRL  = 6'b000010;
  localparam logic [5:0] FN_SRA  = 6'b000011;
  localparam logic [5:0] FN_SLLV = 6'b000100;
  localparam logic [5:0] FN_SRLV = 6'b000110;
  localparam logic [5:0] FN_SRAV = 6'b000111;
  localparam logic [5:0] FN_JR   = 6'b001000;
  localparam logic [5:0] FN_JALR = 6'b001001;
  localparam logic [5:0] FN_ADD  = 6'b100000;
  localparam logic [5:0] FN_ADDU = 6'b100001;
  localparam logic [5:0] FN_SUB  = 6'b100010;
  localparam logic [5:0] FN_SUBU = 6'b100011;
  localparam logic [5:0] FN_AND  = 6'b100100;
  localparam logic [5:0] FN_OR   = 6'b100101;
  localparam logic [5:0] FN_XOR  = 6'b100110;
  localparam logic [5:0] FN_NOR  = 6'b100111;
  localparam logic [5:0] FN_SLT  = 6'b101010;
  localparam logic [5:0] FN_SLTU = 6'b101011;

  typedef enum logic [5:0] {
    ALU_NOP = 6'd0,
    ALU_OR, ALU_AND, ALU_XOR, ALU_NOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV, ALU_SRAV,
    ALU_SLT, ALU_SLTU, ALU_ADD, ALU_ADDU, ALU_ADDI, ALU_ADDIU, ALU_SUB, ALU_SUBU,
    ALU_LW, ALU_SW,
    ALU_J, ALU_JAL, ALU_JR, ALU_JALR, ALU_BEQ
  } aluop_e;

  typedef enum logic [2:0] {
    SEL_NOP = 3'd0,
    SEL_LOGIC,
    SEL_SHIFT,
    SEL_ARITHMETIC,
    SEL_JUMP_BRANCH,
    SEL_LOAD_STORE
  } alusel_e;

  typedef enum logic [2:0] {
    BR_NONE = 3'd0,
    BR_JUMP_IMM,
    BR_JUMP_REG,
    BR_BEQ
  } branch_kind_e;

  // result of a later stage, also the write-back port
  typedef struct packed {
    logic      wreg;
    reg_addr_t wd;
    word_t     wdata;
    aluop_e    aluop;
  } fwd_t;

  typedef struct packed {
    aluop_e       aluop;
    alusel_e      alusel;
    reg_addr_t    wd;
    logic         wreg;
    logic         reg1_read;
    logic         reg2_read;
    reg_addr_t    reg1_addr;
    reg_addr_t    reg2_addr;
    word_t        imm;
    branch_kind_e branch_kind;
    logic         link;
  } decode_t;

  typedef struct packed {
    aluop_e  aluop;
    alusel_e alusel;
    word_t   reg1;
    word_t   reg2;
    reg_addr_t wd;
    logic    wreg;
    word_t   link_addr;
    word_t   inst;
    logic    in_delay_slot;
  } id_ex_t;

endpackage
